// File: vga_defs.svh
// video output stage constants for widths, queue banks, burst headroom and fill colour
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// pixel format

`define VGA_COLOR_W       8           // bits per colour channel

////////////////////////////////////////////////////////////////////////////
// pixel queue

`define VGA_NUM_BANKS     6           // banks in the write rotation
`define VGA_BANK_DEPTH    4096        // words per bank, power of two
`define VGA_BANK_CNT_W    13          // holds 0 .. VGA_BANK_DEPTH
`define VGA_MAX_BURST     342         // room one memory burst needs
`define VGA_MAX_LANES     4           // pixels per write clock

// shown when the queue runs dry in the active area
`define VGA_FILL_COLOR    24'hFF_00_00

`endif

// File: vga_pkg.sv
// shared pixel, counter, modeline and sync types of the video output stage
`default_nettype none

`include "vga_defs.svh"

package vga_pkg;

   typedef struct packed {
      logic [`VGA_COLOR_W-1:0] r;
      logic [`VGA_COLOR_W-1:0] g;
      logic [`VGA_COLOR_W-1:0] b;
   } pixel_t;

   typedef logic [15:0] coord_t;       // pixel or line position
   typedef logic [7:0]  porch_t;       // porch or sync pulse width
   typedef logic [23:0] frame_cnt_t;   // pixels in one frame
   typedef logic [2:0]  bank_idx_t;    // 0 .. 5
   typedef logic [15:0] queue_cnt_t;   // pixels held over all banks

   typedef struct packed {
      coord_t h;                       // visible width
      porch_t hfp;
      porch_t hs;
      porch_t hbp;
      coord_t v;                       // visible height
      porch_t vfp;
      porch_t vs;
      porch_t vbp;
   } modeline_t;

   typedef struct packed {
      logic hsync;                     // active low
      logic vsync;                     // active low
      logic hblank;
      logic vblank;
      logic de;
   } vid_timing_t;

   typedef enum logic [1:0] {
      OUT_LIVE,
      OUT_WAIT_VBLANK,
      OUT_QUEUE
   } out_mode_e;

endpackage

`default_nettype wire

// File: vga_timing.sv
// progressive raster timing generator with run-time modeline and registered sync outputs
`timescale 1ns/1ps
`default_nettype none

module vga_timing import vga_pkg::*; (
   input  logic        clk_sys,
   input  logic        vga_reset,
   input  logic        ce_pix,
   input  modeline_t   modeline,
   output vid_timing_t timing
);

   coord_t      h_cnt;
   coord_t      v_cnt;
   coord_t      h_total;
   coord_t      h_sync_on;
   coord_t      h_sync_off;
   coord_t      v_total;
   coord_t      v_sync_on;
   coord_t      v_sync_off;
   vid_timing_t timing_next;

   ////////////////////////////////////////////////////////////////////////////
   // modeline edges

   assign h_sync_on  = modeline.h + coord_t'(modeline.hfp);
   assign h_sync_off = h_sync_on + coord_t'(modeline.hs);
   assign h_total    = h_sync_off + coord_t'(modeline.hbp);

   assign v_sync_on  = modeline.v + coord_t'(modeline.vfp);
   assign v_sync_off = v_sync_on + coord_t'(modeline.vs);
   assign v_total    = v_sync_off + coord_t'(modeline.vbp);

   ////////////////////////////////////////////////////////////////////////////
   // counters

   always_ff @(posedge clk_sys) begin
      if (vga_reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (ce_pix) begin
         h_cnt <= (h_cnt >= h_total - 16'd1) ? '0 : h_cnt + 16'd1;
         if (h_cnt == h_sync_on) begin        // line step at hsync start
            v_cnt <= (v_cnt >= v_total - 16'd1) ? '0 : v_cnt + 16'd1;
         end
      end
   end

   // decoded from the counts seen at this ce_pix
   always_comb begin
      timing_next.hsync  = !(h_cnt >= h_sync_on && h_cnt < h_sync_off);
      timing_next.vsync  = !(v_cnt >= v_sync_on && v_cnt < v_sync_off);
      timing_next.hblank = h_cnt >= modeline.h;
      timing_next.vblank = v_cnt >= modeline.v;
      timing_next.de     = !timing_next.hblank && !timing_next.vblank;
   end

   always_ff @(posedge clk_sys) begin
      if (vga_reset) begin
         timing <= '{hsync: 1'b1, vsync: 1'b1, hblank: 1'b1, vblank: 1'b1, de: 1'b0};
      end else if (ce_pix) begin
         timing <= timing_next;
      end
   end

   // a zero total would freeze the counters at one position
   a_totals_nonzero: assert property (@(posedge clk_sys) disable iff (vga_reset)
      ce_pix |-> (h_total != '0 && v_total != '0))
      else $error("modeline has a zero total, h %0d v %0d", h_total, v_total);

endmodule

`default_nettype wire

// File: vram_writer.sv
// write packer spreading up to four pixels per clock over the rotating queue banks
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vram_writer import vga_pkg::*; (
   input  logic                                clk_sys,
   input  logic                                vga_reset,
   input  logic                                vram_reset,
   input  modeline_t                           modeline,
   input  logic   [`VGA_MAX_LANES-1:0]         vram_wren,
   input  pixel_t [`VGA_MAX_LANES-1:0]         vram_pix,
   output logic   [`VGA_NUM_BANKS-1:0]         bank_wr,
   output pixel_t [`VGA_NUM_BANKS-1:0]         bank_din,
   output frame_cnt_t                          vram_pixels,
   output logic                                vram_end_frame
);

   bank_idx_t                          wr_base;        // bank taking lane 0
   logic      [2:0]                    lane_cnt;
   logic      [`VGA_NUM_BANKS-1:0]     wr_next;
   pixel_t    [`VGA_NUM_BANKS-1:0]     din_next;
   frame_cnt_t                         frame_pixels;   // h*v
   frame_cnt_t                         count_next;

   function automatic bank_idx_t bank_wrap(input bank_idx_t base, input logic [2:0] step);
      logic [3:0] sum;
      sum = {1'b0, base} + {1'b0, step};
      if (sum >= 4'(`VGA_NUM_BANKS)) begin
         sum = sum - 4'(`VGA_NUM_BANKS);
      end
      return sum[2:0];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // lane k goes to bank (wr_base + k) mod 6

   always_comb begin
      bank_idx_t lane_bank;
      lane_bank = wr_base;
      lane_cnt  = '0;
      wr_next   = '0;
      din_next  = bank_din;                            // idle banks keep their word
      for (int k = 0; k < `VGA_MAX_LANES; k++) begin
         if (vram_wren[k]) begin
            lane_bank           = bank_wrap(wr_base, 3'(k));
            wr_next[lane_bank]  = 1'b1;
            din_next[lane_bank] = vram_pix[k];
            lane_cnt            = lane_cnt + 3'd1;
         end
      end
   end

   // restart at n once the frame was complete
   assign count_next = vram_end_frame ? frame_cnt_t'(lane_cnt)
                                      : vram_pixels + frame_cnt_t'(lane_cnt);

   always_ff @(posedge clk_sys) begin
      if (vga_reset || vram_reset) begin
         wr_base        <= '0;
         bank_wr        <= '0;
         vram_pixels    <= '0;
         vram_end_frame <= 1'b0;
         frame_pixels   <= frame_cnt_t'(modeline.h) * frame_cnt_t'(modeline.v);
      end else begin
         bank_wr <= wr_next;
         if (lane_cnt != '0) begin
            wr_base        <= bank_wrap(wr_base, lane_cnt);
            vram_pixels    <= count_next;
            vram_end_frame <= count_next >= frame_pixels;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      bank_din <= din_next;
   end

   // the rotation assumes lanes fill from lane 0 upward
   a_wren_thermo: assert property (@(posedge clk_sys) disable iff (vga_reset || vram_reset)
      vram_wren inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
      else $error("write lanes not a thermometer code, %b", vram_wren);

endmodule

`default_nettype wire

// File: vram_bank_fifo.sv
// one show-ahead pixel FIFO bank of the output queue with a fill count
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vram_bank_fifo import vga_pkg::*; #(
   parameter int DEPTH = `VGA_BANK_DEPTH
) (
   input  logic                        clk_sys,
   input  logic                        clear,
   input  logic                        wr,
   input  pixel_t                      din,
   input  logic                        rd,
   output pixel_t                      head,
   output logic                        empty,
   output logic [`VGA_BANK_CNT_W-1:0]  count
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [`VGA_BANK_CNT_W-1:0] FULL_CNT = DEPTH[`VGA_BANK_CNT_W-1:0];

   pixel_t          mem [DEPTH];
   logic   [AW-1:0] wr_ptr;
   logic   [AW-1:0] rd_ptr;
   logic            full;
   logic            do_wr;
   logic            do_rd;

   assign full  = count == FULL_CNT;
   assign empty = count == '0;
   assign do_wr = wr && !full;                 // dropped when full
   assign do_rd = rd && !empty;
   assign head  = mem[rd_ptr];                 // oldest word always visible

   always_ff @(posedge clk_sys) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is 2^AW
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // the stream has no back-pressure, so an overrun loses pixels
   a_no_overrun: assert property (@(posedge clk_sys) disable iff (clear)
      !(wr && full))
      else $error("write to a full bank, pixel dropped");

   // the output stage must check empty before it reads
   a_no_underrun: assert property (@(posedge clk_sys) disable iff (clear)
      !(rd && empty))
      else $error("read from an empty bank");

endmodule

`default_nettype wire

// File: vga_pixel_out.sv
// pixel output stage choosing queue, live input, fill colour or black per pixel
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vga_pixel_out import vga_pkg::*; (
   input  logic                                clk_sys,
   input  logic                                vga_reset,
   input  logic                                vram_reset,
   input  logic                                ce_pix,
   input  logic                                vram_active,
   input  vid_timing_t                         timing,
   input  pixel_t                              pix_in,
   input  pixel_t [`VGA_NUM_BANKS-1:0]         bank_head,
   input  logic   [`VGA_NUM_BANKS-1:0]         bank_empty,
   output logic   [`VGA_NUM_BANKS-1:0]         bank_rd,
   output pixel_t                              rgb_out,
   output logic                                vram_synced
);

   out_mode_e mode;
   bank_idx_t rd_idx;          // next bank in the rotation
   bank_idx_t rd_idx_next;
   logic      pix_due;         // visible pixel owed by the queue
   logic      pop;

   assign pix_due     = ce_pix && vram_active && (mode == OUT_QUEUE) && timing.de;
   assign pop         = pix_due && !bank_empty[rd_idx];
   assign rd_idx_next = (rd_idx == bank_idx_t'(`VGA_NUM_BANKS - 1)) ? '0 : rd_idx + 3'd1;

   // head is shown ahead, so the pop and the capture share one edge
   always_comb begin
      bank_rd         = '0;
      bank_rd[rd_idx] = pop;
   end

   ////////////////////////////////////////////////////////////////////////////
   // mode FSM

   always_ff @(posedge clk_sys) begin
      if (vga_reset || vram_reset) begin
         mode <= OUT_WAIT_VBLANK;
      end else if (ce_pix) begin
         case (mode)
            OUT_LIVE: begin
               if (vram_active) mode <= OUT_WAIT_VBLANK;
            end
            OUT_WAIT_VBLANK: begin
               if (!vram_active) mode <= OUT_LIVE;
               else if (timing.vblank) mode <= OUT_QUEUE;  // frame start lines up
            end
            OUT_QUEUE: begin
               if (!vram_active) mode <= OUT_LIVE;
            end
            default: mode <= OUT_WAIT_VBLANK;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // pixel select

   always_ff @(posedge clk_sys) begin
      if (vga_reset || vram_reset) begin
         rd_idx      <= '0;
         rgb_out     <= '0;
         vram_synced <= 1'b1;
      end else if (ce_pix) begin
         if (!timing.de) begin
            rgb_out <= '0;                             // black in blanking
         end else if (!vram_active) begin
            rgb_out <= pix_in;                         // pass-through
         end else if (pop) begin
            rgb_out <= bank_head[rd_idx];
            rd_idx  <= rd_idx_next;
         end else if (pix_due) begin
            rgb_out     <= `VGA_FILL_COLOR;            // queue ran dry
            vram_synced <= 1'b0;                       // held until vram_reset
         end else begin
            rgb_out <= '0;                             // still waiting for vblank
         end
      end
   end

endmodule

`default_nettype wire

// File: vga_top.sv
// video output stage top joining timing, write packer, six queue banks and pixel output
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vga_top import vga_pkg::*; (
   input  logic                                clk_sys,
   input  logic                                vga_reset,
   input  logic                                ce_pix,
   input  logic                                vram_reset,
   input  modeline_t                           modeline,
   input  logic                                vram_active,
   input  logic   [`VGA_MAX_LANES-1:0]         vram_wren,
   input  pixel_t [`VGA_MAX_LANES-1:0]         vram_pix,
   input  pixel_t                              pix_in,
   output logic                                vram_ready,
   output queue_cnt_t                          vram_queue,
   output frame_cnt_t                          vram_pixels,
   output logic                                vram_end_frame,
   output logic                                vram_synced,
   output logic                                hsync,
   output logic                                vsync,
   output logic                                hblank,
   output logic                                vblank,
   output logic                                vga_de,
   output pixel_t                              rgb_out
);

   localparam queue_cnt_t QUEUE_LIMIT =
      queue_cnt_t'(`VGA_NUM_BANKS * `VGA_BANK_DEPTH - `VGA_MAX_BURST);

   vid_timing_t                        timing;
   logic                               bank_clear;
   logic   [`VGA_NUM_BANKS-1:0]        bank_wr;
   logic   [`VGA_NUM_BANKS-1:0]        bank_rd;
   logic   [`VGA_NUM_BANKS-1:0]        bank_empty;
   pixel_t [`VGA_NUM_BANKS-1:0]        bank_din;
   pixel_t [`VGA_NUM_BANKS-1:0]        bank_head;
   logic   [`VGA_BANK_CNT_W-1:0]       bank_count [`VGA_NUM_BANKS];

   assign bank_clear = vga_reset || vram_reset;

   vga_timing u_timing (
      .clk_sys   (clk_sys),
      .vga_reset (vga_reset),
      .ce_pix    (ce_pix),
      .modeline  (modeline),
      .timing    (timing)
   );

   vram_writer u_writer (
      .clk_sys        (clk_sys),
      .vga_reset      (vga_reset),
      .vram_reset     (vram_reset),
      .modeline       (modeline),
      .vram_wren      (vram_wren),
      .vram_pix       (vram_pix),
      .bank_wr        (bank_wr),
      .bank_din       (bank_din),
      .vram_pixels    (vram_pixels),
      .vram_end_frame (vram_end_frame)
   );

   for (genvar b = 0; b < `VGA_NUM_BANKS; b++) begin : g_bank
      vram_bank_fifo #(.DEPTH(`VGA_BANK_DEPTH)) u_bank (
         .clk_sys (clk_sys),
         .clear   (bank_clear),
         .wr      (bank_wr[b]),
         .din     (bank_din[b]),
         .rd      (bank_rd[b]),
         .head    (bank_head[b]),
         .empty   (bank_empty[b]),
         .count   (bank_count[b])
      );
   end

   vga_pixel_out u_pixel_out (
      .clk_sys     (clk_sys),
      .vga_reset   (vga_reset),
      .vram_reset  (vram_reset),
      .ce_pix      (ce_pix),
      .vram_active (vram_active),
      .timing      (timing),
      .pix_in      (pix_in),
      .bank_head   (bank_head),
      .bank_empty  (bank_empty),
      .bank_rd     (bank_rd),
      .rgb_out     (rgb_out),
      .vram_synced (vram_synced)
   );

   ////////////////////////////////////////////////////////////////////////////
   // queue level over all banks

   always_comb begin
      vram_queue = '0;
      for (int b = 0; b < `VGA_NUM_BANKS; b++) begin
         vram_queue = vram_queue + queue_cnt_t'(bank_count[b]);
      end
   end

   assign vram_ready = vram_queue < QUEUE_LIMIT;   // room left for one burst

   assign hsync  = timing.hsync;
   assign vsync  = timing.vsync;
   assign hblank = timing.hblank;
   assign vblank = timing.vblank;
   assign vga_de = timing.de;

endmodule

`default_nettype wire

// File: tb_vga_checker.sv
// testbench checker modeling raster timing, pixel output and queue levels of the video stage
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module tb_vga_checker import vga_pkg::*; (
   input  logic                        clk_sys,
   input  logic                        vga_reset,
   input  logic                        vram_reset,
   input  logic                        ce_pix,
   input  logic                        vram_active,
   input  modeline_t                   modeline,
   input  logic   [`VGA_MAX_LANES-1:0] vram_wren,
   input  pixel_t [`VGA_MAX_LANES-1:0] vram_pix,
   input  pixel_t                      pix_in,
   input  logic                        hsync,
   input  logic                        vsync,
   input  logic                        hblank,
   input  logic                        vblank,
   input  logic                        vga_de,
   input  pixel_t                      rgb_out,
   input  logic                        vram_synced,
   input  frame_cnt_t                  vram_pixels,
   input  logic                        vram_end_frame,
   input  logic                        vram_ready,
   input  queue_cnt_t                  vram_queue,
   input  logic                        cnt_valid,   // file expectation present
   input  logic   [24:0]               cnt_exp,     // {end_frame, pixels}
   output int                          errors,
   output int                          checks
);

   // queue level below which one more burst still fits
   localparam int READY_LIMIT = `VGA_NUM_BANKS * `VGA_BANK_DEPTH - `VGA_MAX_BURST;

   coord_t      h_cnt, v_cnt, hs_on, h_tot, vs_on, v_tot;
   frame_cnt_t  hv, exp_pix;
   vid_timing_t exp_t;
   pixel_t      exp_rgb;
   logic        exp_synced;
   logic        armed;
   out_mode_e   mode;
   pixel_t      pend [$];                          // written, not yet shown
   int          quiet;                             // clocks since queue traffic

   assign hs_on = modeline.h + coord_t'(modeline.hfp);
   assign h_tot = hs_on + coord_t'(modeline.hs) + coord_t'(modeline.hbp);
   assign vs_on = modeline.v + coord_t'(modeline.vfp);
   assign v_tot = vs_on + coord_t'(modeline.vs) + coord_t'(modeline.vbp);
   assign hv    = frame_cnt_t'(modeline.h) * frame_cnt_t'(modeline.v);

   initial begin
      errors = 0;
      checks = 0;
      armed  = 1'b0;
      quiet  = 0;
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got %h expected %h at %0t ns", name, got, exp, $time);
      end
   endtask

   always @(posedge clk_sys) begin
      int n;
      n = $countones(vram_wren);
      if (armed) begin
         compare("hsync", 32'(hsync), 32'(exp_t.hsync));
         compare("vsync", 32'(vsync), 32'(exp_t.vsync));
         compare("hblank", 32'(hblank), 32'(exp_t.hblank));
         compare("vblank", 32'(vblank), 32'(exp_t.vblank));
         compare("vga_de", 32'(vga_de), 32'(exp_t.de));
         compare("rgb_out", 32'(rgb_out), 32'(exp_rgb));
         compare("vram_synced", 32'(vram_synced), 32'(exp_synced));
         compare("vram_pixels", 32'(vram_pixels), 32'(exp_pix));
         compare("vram_end_frame", 32'(vram_end_frame), 32'(exp_pix >= hv));
         if (quiet >= 2) compare("vram_queue", 32'(vram_queue), 32'(pend.size()));
         if (quiet >= 2) compare("vram_ready", 32'(vram_ready), 32'(pend.size() < READY_LIMIT));
         if (cnt_valid) begin
            compare("vram_pixels", 32'(vram_pixels), 32'(cnt_exp[23:0]));
            compare("vram_end_frame", 32'(vram_end_frame), 32'(cnt_exp[24]));
         end
      end
      if (vga_reset) armed = 1'b1;
      quiet = quiet + 1;

      ////////////////////////////////////////////////////////////////////////////
      // output stage and writer model, uses the timing seen before this edge
      if (vga_reset || vram_reset) begin
         mode       = OUT_WAIT_VBLANK;
         exp_rgb    = '0;
         exp_synced = 1'b1;
         exp_pix    = '0;
         quiet      = 0;
         pend.delete();
      end else begin
         if (ce_pix) begin
            if (!exp_t.de) exp_rgb = '0;
            else if (!vram_active) exp_rgb = pix_in;
            else if (mode == OUT_QUEUE) begin
               if (pend.size() > 0) begin
                  exp_rgb = pend.pop_front();
                  quiet   = 0;
               end else begin
                  exp_rgb    = `VGA_FILL_COLOR;     // underrun
                  exp_synced = 1'b0;
               end
            end else exp_rgb = '0;
            if (!vram_active) mode = OUT_LIVE;
            else if (mode == OUT_LIVE) mode = OUT_WAIT_VBLANK;
            else if (mode == OUT_WAIT_VBLANK && exp_t.vblank) mode = OUT_QUEUE;
         end
         if (n > 0) begin
            for (int k = 0; k < n; k++) pend.push_back(vram_pix[k]);
            exp_pix = (exp_pix >= hv) ? frame_cnt_t'(n) : exp_pix + frame_cnt_t'(n);
            quiet   = 0;
         end
      end

      // raster model
      if (vga_reset) begin
         h_cnt = '0;
         v_cnt = '0;
         exp_t = '{hsync: 1'b1, vsync: 1'b1, hblank: 1'b1, vblank: 1'b1, de: 1'b0};
      end else if (ce_pix) begin
         exp_t.hsync  = !(h_cnt >= hs_on && h_cnt < hs_on + coord_t'(modeline.hs));
         exp_t.vsync  = !(v_cnt >= vs_on && v_cnt < vs_on + coord_t'(modeline.vs));
         exp_t.hblank = h_cnt >= modeline.h;
         exp_t.vblank = v_cnt >= modeline.v;
         exp_t.de     = !exp_t.hblank && !exp_t.vblank;
         if (h_cnt == hs_on) v_cnt = (v_cnt == v_tot - 16'd1) ? '0 : v_cnt + 16'd1;
         h_cnt = (h_cnt == h_tot - 16'd1) ? '0 : h_cnt + 16'd1;
      end
   end

endmodule

`default_nettype wire

// File: tb_vga.sv
// testbench top for the video output stage, driven by commands from a data file
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module tb_vga import vga_pkg::*; ();

   logic                        clk_sys;
   logic                        vga_reset;
   logic                        ce_pix = 1'b0;
   logic                        vram_reset;
   logic                        vram_active;
   modeline_t                   modeline;
   logic   [`VGA_MAX_LANES-1:0] vram_wren;
   pixel_t [`VGA_MAX_LANES-1:0] vram_pix;
   pixel_t                      pix_in = '0;
   logic                        vram_ready, vram_end_frame, vram_synced;
   queue_cnt_t                  vram_queue;
   frame_cnt_t                  vram_pixels;
   logic                        hsync, vsync, hblank, vblank, vga_de;
   pixel_t                      rgb_out;
   logic                        cnt_valid;
   logic   [24:0]               cnt_exp;
   int                          errors, checks;
   logic                        bad_cmd;
   logic   [31:0]               words [0:127];
   longint                      limit_ns;

   vga_top u_vga_top (.*);

   tb_vga_checker u_checker (.*);

   initial begin
      clk_sys = 1'b0;
      forever #4 clk_sys = ~clk_sys;
   end

   // random pixel enable gaps and live input
   always @(posedge clk_sys) begin
      ce_pix <= 1'($urandom % 2);
      pix_in <= 24'($urandom);
   end

   function automatic int count_frames();
      int pc;
      int total;
      pc    = 8;
      total = 0;
      while (pc < 128 && words[pc][31:28] != 4'd0) begin
         if (words[pc][31:28] == 4'd3) total += int'(words[pc][27:0]);
         if (words[pc][31:28] == 4'd1) pc += int'(words[pc][27:0]);
         pc++;
      end
      return total;
   endfunction

   task automatic write_pixels(input int count, inout int pc);
      int left;
      int n;
      left = count;
      while (left > 0) begin
         n = 1 + int'($urandom % 4);
         if (n > left) n = left;
         @(posedge clk_sys);
         vram_wren <= 4'((1 << n) - 1);               // thermometer lanes
         for (int k = 0; k < `VGA_MAX_LANES; k++) begin
            vram_pix[k] <= (k < n) ? words[pc + k][23:0] : 24'h0;
         end
         pc += n;
         left -= n;
         @(posedge clk_sys);
         vram_wren <= '0;
         repeat ($urandom % 3) @(posedge clk_sys);
      end
   endtask

   initial begin
      int pc;
      logic [3:0]  op;
      logic [27:0] arg;
      void'($urandom(32'h5e29));
      vga_reset   = 1'b1;
      vram_reset  = 1'b0;
      vram_active = 1'b0;
      vram_wren   = '0;
      vram_pix    = '0;
      cnt_valid   = 1'b0;
      cnt_exp     = '0;
      bad_cmd     = 1'b0;
      $readmemh("tb_vga_input.txt", words);
      modeline.h   = words[0][15:0];
      modeline.hfp = words[1][7:0];
      modeline.hs  = words[2][7:0];
      modeline.hbp = words[3][7:0];
      modeline.v   = words[4][15:0];
      modeline.vfp = words[5][7:0];
      modeline.vs  = words[6][7:0];
      modeline.vbp = words[7][7:0];
      limit_ns = 8 * (longint'(count_frames() + 2) * 4
                 * (words[0] + words[1] + words[2] + words[3])
                 * (words[4] + words[5] + words[6] + words[7]) + 2000);
      repeat (3) @(posedge clk_sys);
      vga_reset <= 1'b0;

      ////////////////////////////////////////////////////////////////////////////
      // command loop
      pc = 8;
      while (!bad_cmd && words[pc][31:28] != 4'd0) begin
         op  = words[pc][31:28];
         arg = words[pc][27:0];
         pc++;
         case (op)
            4'd1: write_pixels(int'(arg), pc);
            4'd2: begin
               @(posedge clk_sys);
               vram_active <= arg[0];
            end
            4'd3: repeat (arg) @(posedge vblank);
            4'd4: begin
               @(posedge clk_sys);
               vram_reset <= 1'b1;
               @(posedge clk_sys);
               vram_reset <= 1'b0;
            end
            4'd5: begin
               repeat (3) @(posedge clk_sys);         // let counts settle
               cnt_exp   <= arg[24:0];
               cnt_valid <= 1'b1;
               @(posedge clk_sys);
               cnt_valid <= 1'b0;
            end
            default: begin
               $display("unknown command word %h in the input file", words[pc - 1]);
               bad_cmd = 1'b1;
            end
         endcase
      end
      repeat (4) @(posedge clk_sys);
      @(negedge clk_sys);                             // checker done with the last edge
      $display("checks %0d, errors %0d, bad commands %0d", checks, errors, bad_cmd);
      if (errors == 0 && !bad_cmd) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #1;
      #(limit_ns);
      $display("watchdog expired after %0d ns, the command sequence did not finish", limit_ns);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_vga_input.txt
// words 0-7: modeline h hfp hs hbp v vfp vs vbp
// then commands, op in [31:28], argument in [27:0]
// 1 write arg pixels (rrggbb words follow), 2 set vram_active, 3 wait arg frames
// 4 vram_reset pulse, 5 expect {end_frame, vram_pixels} in [24:0], 0 end
00000004 00000001 00000001 00000001
00000003 00000001 00000001 00000001
20000000 30000001
1000000C
00102030 00112233 00223344 00334455 00445566 00556677
00667788 00778899 008899AA 0099AABB 00AABBCC 00BBCCDD
5100000C
10000005
000A0B0C 00010203 00F0E0D0 0000FF00 000000FF
50000005
20000001 30000003
40000000 20000000 30000001
00000000

// File: src.f
+incdir+.
vga_pkg.sv
vga_timing.sv
vram_writer.sv
vram_bank_fifo.sv
vga_pixel_out.sv
vga_top.sv
tb_vga_checker.sv
tb_vga.sv

// File: run_sim.sh
#!/bin/sh
# build and run the video stage testbench with Verilator

verilator --binary --timing -f src.f --top-module tb_vga -o tb_vga_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_vga_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
   exit 0
fi
exit 1
